//--- verilog/aluPkg.sv
//////////////////////////////////////////////////
// ALU definitions package
// function codes, code width and register index width
//////////////////////////////////////////////////

`default_nettype none

package aluPkg;

	localparam int szAluFn = 4;
	localparam int szRegIdx = 5;

	// bit 3 subtract/arithmetic, bit 1 unsigned, bit 0 invert compare
	localparam logic [szAluFn-1:0] fnAdd  = 4'd0;
	localparam logic [szAluFn-1:0] fnSl   = 4'd1;
	localparam logic [szAluFn-1:0] fnSeq  = 4'd2;
	localparam logic [szAluFn-1:0] fnSne  = 4'd3;
	localparam logic [szAluFn-1:0] fnXor  = 4'd4;
	localparam logic [szAluFn-1:0] fnSr   = 4'd5;
	localparam logic [szAluFn-1:0] fnOr   = 4'd6;
	localparam logic [szAluFn-1:0] fnAnd  = 4'd7;
	localparam logic [szAluFn-1:0] fnSub  = 4'd10;
	localparam logic [szAluFn-1:0] fnSra  = 4'd11;
	localparam logic [szAluFn-1:0] fnSlt  = 4'd12;
	localparam logic [szAluFn-1:0] fnSge  = 4'd13;
	localparam logic [szAluFn-1:0] fnSltu = 4'd14;
	localparam logic [szAluFn-1:0] fnSgeu = 4'd15;

	function automatic logic isSub(input logic [szAluFn-1:0] fn);
		return fn[3];
	endfunction

	// set-less-than family sits at the top of the code space
	function automatic logic isCmp(input logic [szAluFn-1:0] fn);
		return fn >= fnSlt;
	endfunction

	function automatic logic cmpUnsigned(input logic [szAluFn-1:0] fn);
		return fn[1];
	endfunction

	function automatic logic cmpInverted(input logic [szAluFn-1:0] fn);
		return fn[0];
	endfunction

endpackage

`default_nettype wire

//--- verilog/alu.sv
//////////////////////////////////////////////////
// integer ALU
// adder, comparator, shifter and logic unit, with
// 32-bit word mode results when xLen is 64
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module alu #(
	parameter int xLen = 64
) (
	input  logic                      dw,
	input  logic [aluPkg::szAluFn-1:0] fn,
	input  logic [xLen-1:0]            in1,
	input  logic [xLen-1:0]            in2,
	output logic [xLen-1:0]            out,
	output logic [xLen-1:0]            adderOut,
	output logic                      cmpOut
);

	import aluPkg::*;

	localparam int szShamt = $clog2(xLen);

	logic [xLen-1:0] in2Inv;
	logic [xLen-1:0] in1XorIn2;
	logic slt;
	logic isRight;
	logic [szShamt-1:0] shamt;
	logic [xLen-1:0] shinR;
	logic [xLen-1:0] shin;
	logic [xLen:0] shWide;
	logic [xLen-1:0] shoutR;
	logic [xLen-1:0] shoutL;
	logic [xLen-1:0] shout;
	logic [xLen-1:0] logicOut;
	logic [xLen-1:0] shiftLogic;
	logic [xLen-1:0] preOut;

	// subtract uses in1 + ~in2 + 1
	assign in2Inv = isSub(fn) ? ~in2 : in2;
	assign in1XorIn2 = in1 ^ in2Inv;
	assign adderOut = in1 + in2Inv + {{(xLen-1){1'b0}}, isSub(fn)};

	// differing signs decide the order without the adder
	assign slt = (in1[xLen-1] == in2[xLen-1]) ? adderOut[xLen-1] :
		(cmpUnsigned(fn) ? in2[xLen-1] : in1[xLen-1]);

	// equality compares have bit 3 clear
	assign cmpOut = cmpInverted(fn) ^ (isSub(fn) ? slt : (in1XorIn2 == '0));

	generate
		if (xLen == 64) begin : gShift64
			logic [31:0] shinHi;
			// word shifts fill the upper half with zero or the sign of bit 31
			assign shinHi = dw ? in1[63:32] : {32{isSub(fn) & in1[31]}};
			assign shamt = {in2[5] & dw, in2[4:0]};
			assign shinR = {shinHi, in1[31:0]};
		end else begin : gShift32
			assign shamt = in2[4:0];
			assign shinR = in1;
		end
	endgenerate

	assign isRight = (fn == fnSr) || (fn == fnSra);

	// left shifts run through the right shifter on a bit-reversed operand
	always_comb begin
		for (int i = 0; i < xLen; i++) begin
			shin[i] = isRight ? shinR[i] : shinR[xLen-1-i];
		end
	end

	assign shWide = $signed({isSub(fn) & shin[xLen-1], shin}) >>> shamt;
	assign shoutR = shWide[xLen-1:0];

	always_comb begin
		for (int i = 0; i < xLen; i++) begin
			shoutL[i] = shoutR[xLen-1-i];
		end
	end

	assign shout = (isRight ? shoutR : '0) | ((fn == fnSl) ? shoutL : '0);

	// or is built from xor plus and
	assign logicOut = (((fn == fnXor) || (fn == fnOr)) ? in1XorIn2 : '0) |
		(((fn == fnOr) || (fn == fnAnd)) ? (in1 & in2) : '0);

	assign shiftLogic = {{(xLen-1){1'b0}}, isCmp(fn) & slt} | logicOut | shout;
	assign preOut = ((fn == fnAdd) || (fn == fnSub)) ? adderOut : shiftLogic;

	generate
		if (xLen == 64) begin : gOut64
			// word results are sign-extended from bit 31
			assign out = dw ? preOut : {{32{preOut[31]}}, preOut[31:0]};
		end else begin : gOut32
			assign out = preOut;
		end
	endgenerate

	initial begin
		assert (xLen == 32 || xLen == 64)
		else $fatal(1, "alu: xLen must be 32 or 64, got %0d", xLen);
	end

endmodule

`default_nettype wire

//--- verilog/regFile.sv
//////////////////////////////////////////////////
// integer register file
// two combinational reads, one write, x0 reads zero
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module regFile #(
	parameter int xLen = 64
) (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic [aluPkg::szRegIdx-1:0] raddr1,
	input  logic [aluPkg::szRegIdx-1:0] raddr2,
	output logic [xLen-1:0]             rdata1,
	output logic [xLen-1:0]             rdata2,
	input  logic                       wen,
	input  logic [aluPkg::szRegIdx-1:0] waddr,
	input  logic [xLen-1:0]             wdata
);

	import aluPkg::*;

	localparam int nRegs = 2 ** szRegIdx;

	// no storage behind x0
	logic [xLen-1:0] regs [1:nRegs-1];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 1; i < nRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- verilog/execStage.sv
//////////////////////////////////////////////////
// execute stage
// issue register, operand bypass, ALU and the
// result register that also drives writeback
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module execStage #(
	parameter int xLen = 64
) (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic                       issueValid,
	input  logic [aluPkg::szAluFn-1:0]  fn,
	input  logic                       dw,
	input  logic [aluPkg::szRegIdx-1:0] rs1,
	input  logic [aluPkg::szRegIdx-1:0] rs2,
	input  logic [aluPkg::szRegIdx-1:0] rd,
	input  logic                       useImm,
	input  logic [xLen-1:0]             imm,
	input  logic [xLen-1:0]             rdata1,
	input  logic [xLen-1:0]             rdata2,
	output logic [aluPkg::szRegIdx-1:0] raddr1,
	output logic [aluPkg::szRegIdx-1:0] raddr2,
	output logic                       wen,
	output logic [aluPkg::szRegIdx-1:0] waddr,
	output logic [xLen-1:0]             wdata,
	output logic                       resultValid,
	output logic [xLen-1:0]             result,
	output logic                       cmpOut,
	output logic [aluPkg::szRegIdx-1:0] resultRd
);

	import aluPkg::*;

	logic issValid;
	logic [szAluFn-1:0] issFn;
	logic issDw;
	logic [szRegIdx-1:0] issRs1;
	logic [szRegIdx-1:0] issRs2;
	logic [szRegIdx-1:0] issRd;
	logic issUseImm;
	logic [xLen-1:0] issImm;

	logic fwd1;
	logic fwd2;
	logic [xLen-1:0] op1;
	logic [xLen-1:0] op2;
	logic [xLen-1:0] aluOut;
	logic aluCmp;

	logic resValid;
	logic [xLen-1:0] resData;
	logic resCmp;
	logic [szRegIdx-1:0] resRd;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			issValid <= 1'b0;
		end else begin
			issValid <= issueValid;
		end
	end

	// operation fields, captured on issue
	always_ff @(posedge clk) begin
		if (issueValid) begin
			issFn <= fn;
			issDw <= dw;
			issRs1 <= rs1;
			issRs2 <= rs2;
			issRd <= rd;
			issUseImm <= useImm;
			issImm <= imm;
		end
	end

	assign raddr1 = issRs1;
	assign raddr2 = issRs2;

	// pending result not yet in the register file
	assign fwd1 = wen && (waddr != '0) && (waddr == issRs1);
	assign fwd2 = wen && (waddr != '0) && (waddr == issRs2);
	assign op1 = fwd1 ? wdata : rdata1;
	assign op2 = issUseImm ? issImm : (fwd2 ? wdata : rdata2);

	// adder output feeds address generation in a full core
	alu #(.xLen(xLen)) alu_inst (
		.dw(issDw),
		.fn(issFn),
		.in1(op1),
		.in2(op2),
		.out(aluOut),
		.adderOut(),
		.cmpOut(aluCmp)
	);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			resValid <= 1'b0;
			resData <= '0;
			resCmp <= 1'b0;
			resRd <= '0;
		end else begin
			resValid <= issValid;
			if (issValid) begin
				resData <= aluOut;
				resCmp <= aluCmp;
				resRd <= issRd;
			end
		end
	end

	// one register serves both writeback and the outputs
	assign wen = resValid;
	assign waddr = resRd;
	assign wdata = resData;
	assign resultValid = resValid;
	assign result = resData;
	assign cmpOut = resCmp;
	assign resultRd = resRd;

	aIssueToResult: assert property (
		@(posedge clk) disable iff (!rstN) issueValid |-> ##2 resultValid
	);
	aResultFromIssue: assert property (
		@(posedge clk) disable iff (!rstN) resultValid |-> $past(issueValid, 2)
	);

endmodule

`default_nettype wire

//--- verilog/execTop.sv
//////////////////////////////////////////////////
// execute slice top level
// register file beside the execute stage it feeds
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module execTop #(
	parameter int xLen = 64
) (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic                       issueValid,
	input  logic [aluPkg::szAluFn-1:0]  fn,
	input  logic                       dw,
	input  logic [aluPkg::szRegIdx-1:0] rs1,
	input  logic [aluPkg::szRegIdx-1:0] rs2,
	input  logic [aluPkg::szRegIdx-1:0] rd,
	input  logic                       useImm,
	input  logic [xLen-1:0]             imm,
	output logic                       resultValid,
	output logic [xLen-1:0]             result,
	output logic                       cmpOut,
	output logic [aluPkg::szRegIdx-1:0] resultRd
);

	import aluPkg::*;

	logic [szRegIdx-1:0] raddr1;
	logic [szRegIdx-1:0] raddr2;
	logic [xLen-1:0] rdata1;
	logic [xLen-1:0] rdata2;
	logic wen;
	logic [szRegIdx-1:0] waddr;
	logic [xLen-1:0] wdata;

	regFile #(.xLen(xLen)) regFile_inst (
		.clk(clk),
		.rstN(rstN),
		.raddr1(raddr1),
		.raddr2(raddr2),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.wen(wen),
		.waddr(waddr),
		.wdata(wdata)
	);

	execStage #(.xLen(xLen)) execStage_inst (
		.clk(clk),
		.rstN(rstN),
		.issueValid(issueValid),
		.fn(fn),
		.dw(dw),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.useImm(useImm),
		.imm(imm),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.raddr1(raddr1),
		.raddr2(raddr2),
		.wen(wen),
		.waddr(waddr),
		.wdata(wdata),
		.resultValid(resultValid),
		.result(result),
		.cmpOut(cmpOut),
		.resultRd(resultRd)
	);

endmodule

`default_nettype wire

//--- verification/tb.sv
//////////////////////////////////////////////////
// execute slice testbench
// replays ALU operations from a data file and checks
// result, compare bit, destination and pulse timing
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb;

	import aluPkg::*;

	localparam int xLen = 64;
	localparam int maxRecs = 64;
	// flags fn dw rs1 rs2 rd useImm imm result cmp, as hex digits
	localparam int recBits = 172;

	logic clk;
	logic rstN;
	logic issueValid;
	logic [szAluFn-1:0] fn;
	logic dw;
	logic [szRegIdx-1:0] rs1;
	logic [szRegIdx-1:0] rs2;
	logic [szRegIdx-1:0] rd;
	logic useImm;
	logic [xLen-1:0] imm;
	logic resultValid;
	logic [xLen-1:0] result;
	logic cmpOut;
	logic [szRegIdx-1:0] resultRd;

	logic [recBits-1:0] recs [0:maxRecs-1];
	int nRecs;
	int nGaps;
	int cycles;
	int limit;
	int checks;
	int valueErrors;
	int pulseErrors;
	// record index and the cycle its result is due
	int pendIdx[$];
	int pendDue[$];

	execTop #(.xLen(xLen)) execTop_inst (
		.clk(clk),
		.rstN(rstN),
		.issueValid(issueValid),
		.fn(fn),
		.dw(dw),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.useImm(useImm),
		.imm(imm),
		.resultValid(resultValid),
		.result(result),
		.cmpOut(cmpOut),
		.resultRd(resultRd)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	task automatic applyRecord(input int i);
		logic [recBits-1:0] rec;
		rec = recs[i];
		issueValid = 1'b1;
		fn = rec[167:164];
		dw = rec[160];
		rs1 = rec[156:152];
		rs2 = rec[148:144];
		rd = rec[140:136];
		useImm = rec[132];
		imm = rec[131:68];
		// issue edge, result edge, then seen on the edge after
		pendIdx.push_back(i);
		pendDue.push_back(cycles + 3);
	endtask

	task automatic compareResult(input int idx);
		logic [recBits-1:0] rec;
		rec = recs[idx];
		checks++;
		if (rec[169] == 1'b0) begin
			if (result !== rec[67:4]) begin
				$display("Fail at %0t: record %0d result expected %h, got %h",
					$time, idx, rec[67:4], result);
				valueErrors++;
			end
		end
		if (rec[3:0] != 4'd2) begin
			if (cmpOut !== rec[0]) begin
				$display("Fail at %0t: record %0d cmpOut expected %b, got %b",
					$time, idx, rec[0], cmpOut);
				valueErrors++;
			end
		end
		if (resultRd !== rec[140:136]) begin
			$display("Fail at %0t: record %0d resultRd expected %0d, got %0d",
				$time, idx, rec[140:136], resultRd);
			valueErrors++;
		end
	endtask

	task automatic checkOutputs();
		int idx;
		while (pendDue.size() != 0 && pendDue[0] < cycles) begin
			idx = pendIdx.pop_front();
			void'(pendDue.pop_front());
			$display("Missing result: no resultValid for record %0d by cycle %0d", idx, cycles);
			pulseErrors++;
		end
		if (resultValid) begin
			if (pendIdx.size() == 0) begin
				$display("Extra result: resultValid high at cycle %0d with nothing issued", cycles);
				pulseErrors++;
			end else if (pendDue[0] != cycles) begin
				$display("Early result: resultValid at cycle %0d, due at cycle %0d",
					cycles, pendDue[0]);
				pulseErrors++;
			end else begin
				idx = pendIdx.pop_front();
				void'(pendDue.pop_front());
				compareResult(idx);
			end
		end
	endtask

	// outputs are registered, so the old values are read here
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout: run stopped after %0d cycles", cycles);
			$display("Testbench failed");
			$finish;
		end else if (rstN) begin
			checkOutputs();
		end
	end

	initial begin
		int i;
		rstN = 1'b0;
		issueValid = 1'b0;
		fn = '0;
		dw = 1'b0;
		rs1 = '0;
		rs2 = '0;
		rd = '0;
		useImm = 1'b0;
		imm = '0;
		cycles = 0;
		checks = 0;
		valueErrors = 0;
		pulseErrors = 0;
		// all ones marks an entry that the file did not fill
		for (i = 0; i < maxRecs; i++) begin
			recs[i] = '1;
		end
		$readmemh("verification/aluTestdata.txt", recs);
		nRecs = 0;
		nGaps = 0;
		while (nRecs < maxRecs && recs[nRecs] != '1) begin
			if (recs[nRecs][168]) begin
				nGaps++;
			end
			nRecs++;
		end
		limit = nRecs + nGaps + 20;
		if (nRecs == 0) begin
			$display("No records were loaded from the data file");
		end
		repeat (2) @(negedge clk);
		rstN = 1'b1;
		for (i = 0; i < nRecs; i++) begin
			if (recs[i][168]) begin
				issueValid = 1'b0;
				@(negedge clk);
			end
			applyRecord(i);
			@(negedge clk);
		end
		issueValid = 1'b0;
		while (pendIdx.size() != 0) begin
			@(negedge clk);
		end
		// a few quiet cycles catch a stray pulse
		repeat (3) @(negedge clk);
		$display("checks %0d, wrong values %0d, result pulse errors %0d",
			checks, valueErrors, pulseErrors);
		if (valueErrors == 0 && pulseErrors == 0 && checks > 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/aluTestdata.txt
// flags_fn_dw_rs1_rs2_rd_useImm_imm(64)_expected result(64)_expected cmpOut
// flags bit0 idle cycle before issue, bit1 result unchecked; cmpOut 2 is unchecked
0_0_1_00_00_01_1_00000000_00000005_00000000_00000005_2
0_0_1_00_00_02_1_FFFFFFFF_FFFFFFFD_FFFFFFFF_FFFFFFFD_2
0_0_1_00_00_03_1_7FFFFFFF_FFFFFFFF_7FFFFFFF_FFFFFFFF_2
0_0_1_00_00_04_1_80000000_00000000_80000000_00000000_2
0_0_1_00_00_05_1_00000000_7FFFFFFF_00000000_7FFFFFFF_2
0_0_1_00_00_06_1_12345678_9ABCDEF0_12345678_9ABCDEF0_2
0_0_1_00_00_07_1_0F0F0F0F_F0F0F0F0_0F0F0F0F_F0F0F0F0_2
0_0_1_00_00_00_1_00000000_00001111_00000000_00001111_2
0_0_1_00_00_08_1_00000000_00000000_00000000_00000000_2
0_0_1_01_02_0A_0_00000000_00000000_00000000_00000002_2
0_A_1_01_02_0B_0_00000000_00000000_00000000_00000008_2
0_0_0_05_01_0D_0_00000000_00000000_FFFFFFFF_80000004_2
0_A_0_01_05_0E_0_00000000_00000000_FFFFFFFF_80000006_2
0_0_0_06_00_0F_1_00000000_00000010_FFFFFFFF_9ABCDF00_2
0_A_1_04_01_10_0_00000000_00000000_7FFFFFFF_FFFFFFFB_2
0_C_1_02_01_11_0_00000000_00000000_00000000_00000001_1
0_E_1_02_01_12_0_00000000_00000000_00000000_00000000_0
0_E_1_01_02_14_0_00000000_00000000_00000000_00000001_1
0_C_1_04_03_15_0_00000000_00000000_00000000_00000001_1
0_E_1_04_03_16_0_00000000_00000000_00000000_00000000_0
2_2_1_01_01_00_0_00000000_00000000_00000000_00000000_1
2_2_1_01_02_00_0_00000000_00000000_00000000_00000000_0
2_3_1_01_02_00_0_00000000_00000000_00000000_00000000_1
2_D_1_02_01_00_0_00000000_00000000_00000000_00000000_0
2_D_1_01_01_00_0_00000000_00000000_00000000_00000000_1
2_F_1_02_01_00_0_00000000_00000000_00000000_00000000_1
0_1_1_06_00_18_1_00000000_00000000_12345678_9ABCDEF0_2
0_1_1_01_00_19_1_00000000_0000003F_80000000_00000000_2
0_5_1_04_00_1A_1_00000000_0000003F_00000000_00000001_2
0_B_1_04_00_1B_1_00000000_0000003F_FFFFFFFF_FFFFFFFF_2
0_B_1_04_00_1C_1_00000000_00000020_FFFFFFFF_80000000_2
0_5_1_06_00_1D_1_00000000_0000001F_00000000_2468ACF1_2
0_1_0_06_00_1E_1_00000000_00000024_FFFFFFFF_ABCDEF00_2
0_5_0_06_00_1F_1_00000000_0000003F_00000000_00000001_2
0_B_0_06_00_18_1_00000000_00000020_FFFFFFFF_9ABCDEF0_2
0_B_0_06_00_19_1_00000000_00000004_FFFFFFFF_F9ABCDEF_2
0_7_1_06_07_0A_0_00000000_00000000_02040608_90B0D0F0_2
0_6_1_06_07_0B_0_00000000_00000000_1F3F5F7F_FAFCFEF0_2
0_4_1_06_07_0C_0_00000000_00000000_1D3B5977_6A4C2E00_2
0_0_1_00_00_0E_1_00000000_00000010_00000000_00000010_2
0_0_1_0E_0E_0E_0_00000000_00000000_00000000_00000020_2
0_1_1_0E_00_0F_1_00000000_00000003_00000000_00000100_2
0_A_1_0F_0E_10_0_00000000_00000000_00000000_000000E0_2
0_4_1_10_00_0E_1_00000000_000000FF_00000000_0000001F_2
1_0_1_00_00_0E_1_00000000_00000010_00000000_00000010_2
1_0_1_0E_0E_0E_0_00000000_00000000_00000000_00000020_2
1_1_1_0E_00_0F_1_00000000_00000003_00000000_00000100_2
1_A_1_0F_0E_10_0_00000000_00000000_00000000_000000E0_2
1_4_1_10_00_0E_1_00000000_000000FF_00000000_0000001F_2

//--- tb.f
verilog/aluPkg.sv
verilog/alu.sv
verilog/regFile.sv
verilog/execStage.sv
verilog/execTop.sv
verification/tb.sv

//--- run.sh
#!/bin/sh
# build and run the execute slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb -o Vtb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
	exit 1
fi
exit 0
